// File: src/tx_adapt_pkg.sv
/* TX adapter shared types and width decode */
`default_nettype none

package tx_adapt_pkg;

   localparam int MAX_IWIDTH = 67;  // Widest fabric word
   localparam int MAX_OWIDTH = 64;  // Widest transceiver word

   // FIFO mode encoding, low two bits carry the phase-comp decode
   typedef enum logic [2:0] {
      phcomp        = 3'd0,
      intl_generic  = 3'd1,
      elastic       = 3'd2,
      register      = 3'd3,
      basic_generic = 3'd5
   } fifo_mode_e;

   // Gearbox input width codes
   typedef enum logic [2:0] {
      iw66 = 3'd0,
      iw67 = 3'd1,
      iw50 = 3'd2,
      iw40 = 3'd3,
      iw32 = 3'd4,
      iw64 = 3'd5
   } gb_iwidth_e;

   // Gearbox output width codes
   typedef enum logic [1:0] {
      ow32 = 2'd0,
      ow40 = 2'd1,
      ow64 = 2'd2
   } gb_owidth_e;

   function automatic logic [6:0] in_width(input gb_iwidth_e code);
      case (code)
         iw64:    return 7'd64;
         iw32:    return 7'd32;
         iw40:    return 7'd40;
         iw50:    return 7'd50;
         iw67:    return 7'd67;
         default: return 7'd66;  // Unused codes fall back to 66
      endcase
   endfunction

   function automatic logic [6:0] out_width(input gb_owidth_e code);
      case (code)
         ow64:    return 7'd64;
         ow40:    return 7'd40;
         default: return 7'd32;
      endcase
   endfunction

   // Frame sequence limit per input bit count
   function automatic logic [6:0] seq_threshold(input logic [6:0] width);
      case (width)
         7'd50:   return 7'd24;
         7'd67:   return 7'd66;
         7'd64:   return 7'd31;
         default: return 7'd32;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: src/tx_fifo.sv
/* TX show-ahead FIFO */
`timescale 1ns/10ps
`default_nettype none

module tx_fifo import tx_adapt_pkg::*; #(
   parameter int FIFO_DEPTH   = 16,  // Words of storage
   parameter int PEMPTY_LEVEL = 2    // Partial-empty at or below this
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic                  wr_en,      // Fabric write strobe
   input  wire logic [MAX_IWIDTH-1:0] wr_data,
   input  wire logic                  rd_en,      // Pop head word
   output logic      [MAX_IWIDTH-1:0] rd_data,    // Head word, always visible
   output logic                       full,
   output logic                       empty,
   output logic                       rd_pempty
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   // ************************************************************
   // Storage and pointers
   // ************************************************************
   logic [MAX_IWIDTH-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [CW-1:0]         count;     // Occupancy
   logic                  wr_ok;
   logic                  rd_ok;

   assign wr_ok = wr_en && !full;    // Write while full is dropped
   assign rd_ok = rd_en && !empty;   // Read on empty is ignored

   // Data array
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap at the last entry, depth need not be a power of two
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle or simultaneous push and pop
         endcase
      end
   end

   // ************************************************************
   // Flags
   // ************************************************************
   assign full      = (count == CW'(FIFO_DEPTH));
   assign empty     = (count == '0);
   assign rd_pempty = (count <= CW'(PEMPTY_LEVEL));  // Drives first-read wait

   assign rd_data = mem[rd_ptr];  // Show-ahead

endmodule

`default_nettype wire

// File: src/tx_dv_gen.sv
/* TX data-valid generator */
`timescale 1ns/10ps
`default_nettype none

module tx_dv_gen import tx_adapt_pkg::*; #(
   parameter int SEL_WIDTH = 7   // Leftover bit counter width
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 r_dv_indv,       // Individual, not bonded
   input  wire gb_iwidth_e           r_gb_idwidth,
   input  wire gb_owidth_e           r_gb_odwidth,
   input  wire fifo_mode_e           r_fifo_mode,
   input  wire logic                 r_gb_dv_en,      // Half-rate toggling on
   input  wire logic                 rd_pempty,
   input  wire logic                 phcomp_rden,
   input  wire logic                 comp_dv_en_reg,  // Bonded enable
   output logic                      start_dv,
   output logic                      data_valid_2x,
   output logic                      data_valid_out,  // Read one input word
   output logic                      word_strobe,     // Emit one output word
   output logic      [SEL_WIDTH-1:0] sel_cnt,         // Leftover bits in gearbox
   output logic      [19:0]          dv_gen_testbus
);

   logic [6:0] iw_bits;
   logic [6:0] ow_bits;
   logic [6:0] threshold;
   logic       phcomp_mode;
   logic       first_read;   // Waiting on first partial-empty drop
   logic       dv_2x;
   logic       dv_en;        // Generator advance enable
   logic [2:0] gap_cnt;      // Strobes left before next read
   logic [6:0] dv_seq_cnt;   // Frame sequence position
   logic [8:0] m_sel;        // Leftover plus input bits
   logic [8:0] ow_x1;
   logic [8:0] ow_x2;
   logic [8:0] ow_x3;
   logic [8:0] ow_x4;
   logic [8:0] ow_x5;

   // ************************************************************
   // Mode and width decode
   // ************************************************************
   assign phcomp_mode = (r_fifo_mode[1:0] == 2'b00);  // Phase-comp family
   assign iw_bits     = in_width(r_gb_idwidth);
   assign ow_bits     = out_width(r_gb_odwidth);
   assign threshold   = seq_threshold(iw_bits);

   // Enable source select
   assign dv_en = (phcomp_rden && phcomp_mode && r_dv_indv) ||   // Phase-comp individual
                  (!first_read && r_dv_indv && !phcomp_mode) ||  // Other individual modes
                  (comp_dv_en_reg && !r_dv_indv);                // Bonded

   // First read waits until FIFO has filled past partial-empty
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         first_read <= 1'b1;
      end else if (!rd_pempty && first_read) begin
         first_read <= 1'b0;
      end
   end

   // ************************************************************
   // Half-rate strobe and frame sequence
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dv_2x <= 1'b0;
      end else if (dv_en) begin
         dv_2x <= r_gb_dv_en ? !dv_2x : 1'b1;  // Held high when toggling is off
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dv_seq_cnt <= '0;
      end else if (word_strobe) begin
         dv_seq_cnt <= (dv_seq_cnt < threshold) ? dv_seq_cnt + 1'b1 : '0;
      end
   end

   assign start_dv      = (dv_seq_cnt == '0) && dv_en;
   assign data_valid_2x = dv_2x;
   assign word_strobe   = dv_en && dv_2x;
   assign data_valid_out = word_strobe && (gap_cnt == 3'd0);  // Active dv_2x only

   // ************************************************************
   // Select and gap counters
   // ************************************************************
   assign m_sel = 9'(iw_bits) + 9'(sel_cnt);
   assign ow_x1 = 9'(ow_bits);
   assign ow_x2 = ow_x1 << 1;
   assign ow_x3 = ow_x2 + ow_x1;
   assign ow_x4 = ow_x1 << 2;
   assign ow_x5 = ow_x4 + ow_x1;

   // Whole output words in m_sel, capped at five
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sel_cnt <= '0;
         gap_cnt <= '0;
      end else if (word_strobe) begin
         if (gap_cnt == 3'd0) begin
            if (m_sel >= ow_x5) begin
               sel_cnt <= SEL_WIDTH'(m_sel - ow_x5);
               gap_cnt <= 3'd4;
            end else if (m_sel >= ow_x4) begin
               sel_cnt <= SEL_WIDTH'(m_sel - ow_x4);
               gap_cnt <= 3'd3;
            end else if (m_sel >= ow_x3) begin
               sel_cnt <= SEL_WIDTH'(m_sel - ow_x3);
               gap_cnt <= 3'd2;
            end else if (m_sel >= ow_x2) begin
               sel_cnt <= SEL_WIDTH'(m_sel - ow_x2);
               gap_cnt <= 3'd1;
            end else begin
               sel_cnt <= SEL_WIDTH'(m_sel - ow_x1);  // Single word, read again next
               gap_cnt <= 3'd0;
            end
         end else begin
            gap_cnt <= gap_cnt - 3'd1;
         end
      end
   end

   // Debug bus, zero padded at the top
   assign dv_gen_testbus = {{(13 - SEL_WIDTH){1'b0}}, gap_cnt, sel_cnt,
                            start_dv, dv_en, dv_2x, data_valid_out};

endmodule

`default_nettype wire

// File: src/tx_gearbox.sv
/* TX width-conversion gearbox */
`timescale 1ns/10ps
`default_nettype none

module tx_gearbox import tx_adapt_pkg::*; #(
   parameter int SEL_WIDTH = 7   // Leftover bit count width
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire gb_iwidth_e            r_gb_idwidth,
   input  wire gb_owidth_e            r_gb_odwidth,
   input  wire logic                  load,         // Append head word
   input  wire logic                  word_strobe,  // Shift out one word
   input  wire logic [SEL_WIDTH-1:0]  sel_cnt,      // Bits held before this cycle
   input  wire logic [MAX_IWIDTH-1:0] rd_data,
   output logic      [MAX_OWIDTH-1:0] tx_data,
   output logic                       tx_valid
);

   // Leftover stays below one output word, so this covers the worst case
   localparam int BW = MAX_IWIDTH + MAX_OWIDTH;

   logic [6:0]            iw_bits;
   logic [6:0]            ow_bits;
   logic [BW-1:0]         in_mask;    // Valid input bits
   logic [BW-1:0]         left_mask;  // Valid leftover bits
   logic [BW-1:0]         in_word;
   logic [BW-1:0]         acc_q;      // Bit accumulator, LSB is oldest
   logic [BW-1:0]         acc_app;    // After append
   logic [BW-1:0]         acc_next;   // After shift out
   logic [MAX_OWIDTH-1:0] out_mask;

   // ************************************************************
   // Width decode and masks
   // ************************************************************
   assign iw_bits = in_width(r_gb_idwidth);
   assign ow_bits = out_width(r_gb_odwidth);

   assign in_mask   = ~({BW{1'b1}} << iw_bits);
   assign left_mask = ~({BW{1'b1}} << sel_cnt);
   assign out_mask  = ~({MAX_OWIDTH{1'b1}} << ow_bits);  // All ones for 64

   assign in_word = BW'(rd_data) & in_mask;  // Drop bits above input width

   // ************************************************************
   // Append and shift
   // ************************************************************
   always_comb begin
      if (load) begin
         acc_app = (acc_q & left_mask) | (in_word << sel_cnt);  // New bits above leftover
      end else begin
         acc_app = acc_q;
      end
   end

   always_comb begin
      if (word_strobe) begin
         acc_next = acc_app >> ow_bits;  // Oldest word leaves
      end else begin
         acc_next = acc_app;
      end
   end

   always_ff @(posedge clk) begin
      acc_q <= acc_next;
   end

   // Output word register
   always_ff @(posedge clk) begin
      if (word_strobe) begin
         tx_data <= acc_app[MAX_OWIDTH-1:0] & out_mask;  // Upper bits zero below 64
      end
   end

   // Valid follows the strobe by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= word_strobe;
      end
   end

endmodule

`default_nettype wire

// File: src/tx_adapt_top.sv
/* TX adapter top level */
`timescale 1ns/10ps
`default_nettype none

module tx_adapt_top import tx_adapt_pkg::*; #(
   parameter int FIFO_DEPTH   = 16,
   parameter int PEMPTY_LEVEL = 2,
   parameter int SEL_WIDTH    = 7
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   // Configuration
   input  wire logic                  r_dv_indv,
   input  wire gb_iwidth_e            r_gb_idwidth,
   input  wire gb_owidth_e            r_gb_odwidth,
   input  wire fifo_mode_e            r_fifo_mode,
   input  wire logic                  r_gb_dv_en,
   // Fabric side
   input  wire logic                  wr_en,
   input  wire logic [MAX_IWIDTH-1:0] wr_data,
   input  wire logic                  phcomp_rden,
   input  wire logic                  comp_dv_en_reg,
   output logic                       full,
   // Transceiver side
   output logic      [MAX_OWIDTH-1:0] tx_data,
   output logic                       tx_valid,
   output logic                       start_dv,
   output logic                       data_valid_out,
   output logic                       data_valid_2x,
   output logic      [19:0]           dv_gen_testbus
);

   logic [MAX_IWIDTH-1:0] rd_data;      // FIFO head word
   logic                  rd_pempty;
   logic                  word_strobe;
   logic [SEL_WIDTH-1:0]  sel_cnt;

   // ************************************************************
   // Input FIFO
   // ************************************************************
   tx_fifo #(
      .FIFO_DEPTH   (FIFO_DEPTH),
      .PEMPTY_LEVEL (PEMPTY_LEVEL)
   ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .rd_en     (data_valid_out),  // One pop per generator read
      .rd_data   (rd_data),
      .full      (full),
      .empty     (),                // No consumer at this level
      .rd_pempty (rd_pempty)
   );

   // Read and emit scheduling
   tx_dv_gen #(
      .SEL_WIDTH (SEL_WIDTH)
   ) u_dv_gen (
      .clk            (clk),
      .rst_n          (rst_n),
      .r_dv_indv      (r_dv_indv),
      .r_gb_idwidth   (r_gb_idwidth),
      .r_gb_odwidth   (r_gb_odwidth),
      .r_fifo_mode    (r_fifo_mode),
      .r_gb_dv_en     (r_gb_dv_en),
      .rd_pempty      (rd_pempty),
      .phcomp_rden    (phcomp_rden),
      .comp_dv_en_reg (comp_dv_en_reg),
      .start_dv       (start_dv),
      .data_valid_2x  (data_valid_2x),
      .data_valid_out (data_valid_out),
      .word_strobe    (word_strobe),
      .sel_cnt        (sel_cnt),
      .dv_gen_testbus (dv_gen_testbus)
   );

   // Width conversion
   tx_gearbox #(
      .SEL_WIDTH (SEL_WIDTH)
   ) u_gearbox (
      .clk          (clk),
      .rst_n        (rst_n),
      .r_gb_idwidth (r_gb_idwidth),
      .r_gb_odwidth (r_gb_odwidth),
      .load         (data_valid_out),
      .word_strobe  (word_strobe),
      .sel_cnt      (sel_cnt),
      .rd_data      (rd_data),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid)
   );

endmodule

`default_nettype wire

// File: dv/tx_adapt_tb.sv
/* TX adapter testbench */
`timescale 1ns/10ps
`default_nettype none

module tx_adapt_tb import tx_adapt_pkg::*; ();

   localparam int FIFO_DEPTH   = 16;
   localparam int PEMPTY_LEVEL = 2;
   localparam int SEL_WIDTH    = 7;
   localparam int FILL_LIMIT   = 12;    // Write while tracked count below this
   localparam int CYCLE_LIMIT  = 8000;  // Seven runs of about 400 cycles plus margin
   localparam int GATE_NONE    = 0;
   localparam int GATE_PHCOMP  = 1;
   localparam int GATE_BOND    = 2;

   // DUT inputs start at known values
   logic                  clk = 1'b0;
   logic                  rst_n = 1'b0;
   logic                  r_dv_indv = 1'b1;
   gb_iwidth_e            r_gb_idwidth = iw66;
   gb_owidth_e            r_gb_odwidth = ow40;
   fifo_mode_e            r_fifo_mode = basic_generic;
   logic                  r_gb_dv_en = 1'b1;
   logic                  wr_en = 1'b0;
   logic [MAX_IWIDTH-1:0] wr_data = '0;
   logic                  phcomp_rden = 1'b0;
   logic                  comp_dv_en_reg = 1'b0;
   logic                  full;
   logic [MAX_OWIDTH-1:0] tx_data;
   logic                  tx_valid;
   logic                  start_dv;
   logic                  data_valid_out;
   logic                  data_valid_2x;
   logic [19:0]           dv_gen_testbus;

   // Run control from the main sequence
   logic                  active = 1'b0;
   string                 test_name = "";
   int                    gate_sel = GATE_NONE;
   int                    hold_len = 0;     // Cycles with writes held off
   int                    n_target = 0;     // Output words per run
   logic                  chk_first = 1'b0;
   logic                  chk_period = 1'b0;
   int                    iw_bits;
   int                    ow_bits;
   int                    period_exp;       // start_dv spacing in cycles
   int                    pass_cnt = 0;
   int                    fail_cnt = 0;
   int                    cycle_cnt = 0;

   // Stimulus state
   logic [31:0]           rng_state = 32'h66e;
   logic [MAX_IWIDTH-1:0] words [512];      // Every word written this run
   int                    n_wr = 0;
   int                    fifo_cnt = 0;     // Tracked FIFO occupancy
   int                    hold_cnt = 0;
   logic                  fed = 1'b0;

   // Compare state
   int                    n_out = 0;
   int                    n_rd = 0;
   int                    err_cnt = 0;
   int                    since_start = 0;
   int                    n_periods = 0;
   logic                  filled = 1'b0;
   logic                  gate_q = 1'b0;
   logic                  sdv_q = 1'b0;
   logic                  seen_start = 1'b0;
   logic                  dv2x_q = 1'b0;    // Model of the half-rate strobe
   logic                  strobe_q = 1'b0;  // Model word strobe of last cycle

   assign iw_bits    = int'(in_width(r_gb_idwidth));
   assign ow_bits    = int'(out_width(r_gb_odwidth));
   assign period_exp = 2 * (int'(seq_threshold(in_width(r_gb_idwidth))) + 1);

   always #2 clk = ~clk;  // 4 ns period

   tx_adapt_top #(
      .FIFO_DEPTH   (FIFO_DEPTH),
      .PEMPTY_LEVEL (PEMPTY_LEVEL),
      .SEL_WIDTH    (SEL_WIDTH)
   ) UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .r_dv_indv      (r_dv_indv),
      .r_gb_idwidth   (r_gb_idwidth),
      .r_gb_odwidth   (r_gb_odwidth),
      .r_fifo_mode    (r_fifo_mode),
      .r_gb_dv_en     (r_gb_dv_en),
      .wr_en          (wr_en),
      .wr_data        (wr_data),
      .phcomp_rden    (phcomp_rden),
      .comp_dv_en_reg (comp_dv_en_reg),
      .full           (full),
      .tx_data        (tx_data),
      .tx_valid       (tx_valid),
      .start_dv       (start_dv),
      .data_valid_out (data_valid_out),
      .data_valid_2x  (data_valid_2x),
      .dv_gen_testbus (dv_gen_testbus)
   );

   // ************************************************************
   // Reference model
   // ************************************************************
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // n-th output word of the LSB-first stream of written words
   function automatic logic [MAX_OWIDTH-1:0] expected_word(input int n, input int iw,
                                                            input int ow);
      logic [MAX_OWIDTH-1:0] res;
      int                    b;
      int                    g;
      res = '0;
      for (b = 0; b < ow; b++) begin
         g = n * ow + b;  // Bit position in whole stream
         res[6'(b)] = words[9'(g / iw)][7'(g % iw)];
      end
      return res;
   endfunction

   // ************************************************************
   // Stimulus keeps FIFO fed and drives the enable gates
   // ************************************************************
   always @(posedge clk) begin : stimulus
      int                    cnt_next;
      logic [MAX_IWIDTH-1:0] word;
      if (!active) begin
         wr_en          <= 1'b0;
         phcomp_rden    <= 1'b0;
         comp_dv_en_reg <= 1'b0;
         fifo_cnt       <= 0;
         n_wr     = 0;
         hold_cnt = hold_len;
         fed      = 1'b0;
      end else begin
         cnt_next = fifo_cnt + (wr_en ? 1 : 0) - (data_valid_out ? 1 : 0);
         fifo_cnt <= cnt_next;
         if (hold_cnt > 0) begin
            hold_cnt--;                  // First-read wait demo
            wr_en <= 1'b0;
         end else if (cnt_next < FILL_LIMIT) begin
            rng_state = lcg_next(rng_state);
            word[31:0] = rng_state;
            rng_state = lcg_next(rng_state);
            word[63:32] = rng_state;
            rng_state = lcg_next(rng_state);
            word[66:64] = rng_state[30:28];
            words[9'(n_wr)] = word;
            n_wr++;
            wr_en   <= 1'b1;
            wr_data <= word;
         end else begin
            wr_en <= 1'b0;
         end
         if (cnt_next >= 4) begin
            fed = 1'b1;                  // Gating starts with a few words queued
         end
         rng_state = lcg_next(rng_state);
         phcomp_rden    <= fed && (gate_sel == GATE_PHCOMP) && rng_state[16];
         comp_dv_en_reg <= fed && (gate_sel == GATE_BOND) && rng_state[16];
      end
   end

   // ************************************************************
   // Compare process
   // ************************************************************
   always @(posedge clk) begin : compare
      int                    errs;
      int                    held;
      logic [MAX_OWIDTH-1:0] exp_word;
      logic [19:0]           bus_exp;
      logic                  gate_now;
      logic                  en_now;
      logic                  strobe_exp;
      logic                  dvo_exp;
      errs = 0;
      gate_now = (gate_sel == GATE_PHCOMP) ? phcomp_rden : comp_dv_en_reg;
      en_now   = (gate_sel == GATE_NONE) ? filled : gate_now;  // Basic mode waits on fill
      if (!active) begin
         n_out       <= 0;
         n_rd        <= 0;
         err_cnt     <= 0;
         n_periods   <= 0;
         since_start <= 0;
         filled      <= 1'b0;
         gate_q      <= 1'b0;
         seen_start  <= 1'b0;
         dv2x_q      <= 1'b0;
         strobe_q    <= 1'b0;
      end else if (n_out < n_target) begin
         strobe_exp = en_now && dv2x_q;
         // Bits held in the gearbox before this cycle
         held       = n_rd * iw_bits - (n_out + (tx_valid ? 1 : 0)) * ow_bits;
         dvo_exp    = strobe_exp && (held < ow_bits);  // Read once no whole word is left
         bus_exp    = {{(13 - SEL_WIDTH){1'b0}}, 3'(held / ow_bits),
                       SEL_WIDTH'(held % ow_bits), start_dv, en_now, dv2x_q, dvo_exp};
         if (chk_first && !filled && (tx_valid || data_valid_out)) begin
            $display("%s: output before the FIFO passed partial-empty", test_name);
            errs++;
         end
         if (fifo_cnt > PEMPTY_LEVEL) begin
            filled <= 1'b1;
         end
         if (gate_sel != GATE_NONE &&
             ((tx_valid && !gate_q) || (data_valid_out && !gate_now))) begin
            $display("%s: output moved on a cycle without its enable", test_name);
            errs++;
         end
         gate_q <= gate_now;  // Enable of the strobe cycle
         if (tx_valid !== strobe_q) begin
            $display("ERR %s: tx_valid expected %0b actual %0b", test_name, strobe_q,
                     tx_valid);
            errs++;
         end
         if (data_valid_2x !== dv2x_q) begin
            $display("ERR %s: data_valid_2x expected %0b actual %0b", test_name, dv2x_q,
                     data_valid_2x);
            errs++;
         end
         if (data_valid_out !== dvo_exp) begin
            $display("ERR %s: data_valid_out expected %0b actual %0b", test_name, dvo_exp,
                     data_valid_out);
            errs++;
         end
         if (full !== (fifo_cnt == FIFO_DEPTH)) begin
            $display("ERR %s: full expected %0b actual %0b", test_name,
                     (fifo_cnt == FIFO_DEPTH), full);
            errs++;
         end
         if (dv_gen_testbus !== bus_exp) begin
            $display("ERR %s: dv_gen_testbus expected %h actual %h", test_name, bus_exp,
                     dv_gen_testbus);
            errs++;
         end
         strobe_q <= strobe_exp;
         if (en_now) begin
            dv2x_q <= !dv2x_q;  // Toggles on every enabled cycle
         end
         if (tx_valid) begin
            exp_word = expected_word(n_out, iw_bits, ow_bits);
            if (tx_data !== exp_word) begin
               $display("ERR %s: word %0d expected %h actual %h", test_name, n_out,
                        exp_word, tx_data);
               errs++;
            end
            n_out <= n_out + 1;
         end
         if (data_valid_out) begin
            n_rd <= n_rd + 1;
         end
         // Rising-edge spacing of start_dv
         if (chk_period && start_dv && !sdv_q) begin
            if (seen_start && since_start != period_exp) begin
               $display("ERR %s: start_dv period expected %0d actual %0d", test_name,
                        period_exp, since_start);
               errs++;
            end
            if (seen_start) begin
               n_periods <= n_periods + 1;
            end
            seen_start  <= 1'b1;
            since_start <= 1;
         end else begin
            since_start <= since_start + 1;
         end
         err_cnt <= err_cnt + errs;
      end
      sdv_q <= start_dv;
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   // ************************************************************
   // Sequencing
   // ************************************************************
   task automatic apply_reset(output int errs);
      int i;
      errs = 0;
      rst_n <= 1'b0;
      for (i = 0; i <= 10; i++) begin
         if (i == 10) begin
            rst_n <= 1'b1;
         end
         @(posedge clk);
         // Outputs settled from the second reset edge on
         if (i > 0 && {tx_valid, start_dv, data_valid_out} !== 3'b000) begin
            $display("ERR %s: reset outputs cycle %0d expected %b actual %b", test_name, i,
                     3'b000, {tx_valid, start_dv, data_valid_out});
            errs++;
         end
      end
   endtask

   task automatic run_test(input string name, input fifo_mode_e mode, input logic indv,
                           input gb_iwidth_e iwc, input gb_owidth_e owc,
                           input int gate, input int hold, input int nwords);
      int errs;
      int rate_diff;
      active <= 1'b0;
      @(posedge clk);
      test_name = name;
      r_fifo_mode  <= mode;
      r_dv_indv    <= indv;
      r_gb_idwidth <= iwc;
      r_gb_odwidth <= owc;
      r_gb_dv_en   <= 1'b1;
      gate_sel     <= gate;
      hold_len     <= hold;
      n_target     <= nwords;
      chk_first    <= indv && (mode == basic_generic);
      chk_period   <= indv && (mode == basic_generic);  // Enable held high here
      apply_reset(errs);
      active <= 1'b1;
      while (n_out < n_target) begin
         @(posedge clk);
      end
      errs = errs + err_cnt;
      rate_diff = n_rd * iw_bits - n_out * ow_bits;  // Bits left in gearbox
      if (rate_diff < 0 || rate_diff > iw_bits) begin
         $display("%s: %0d reads of %0d bits do not match %0d words of %0d bits", name,
                  n_rd, iw_bits, n_out, ow_bits);
         errs++;
      end
      if (chk_period && n_periods == 0) begin
         $display("%s: no full start_dv period seen", name);
         errs++;
      end
      if (errs == 0) begin
         pass_cnt++;
      end else begin
         fail_cnt++;
      end
      $display("%s %s: %0d words, %0d reads, %0d errors", (errs == 0) ? "PASS" : "FAIL",
               name, n_out, n_rd, errs);
   endtask

   initial begin
      run_test("dint_66_40", basic_generic, 1'b1, iw66, ow40, GATE_NONE, 0, 200);
      run_test("dint_67_64", basic_generic, 1'b1, iw67, ow64, GATE_NONE, 0, 200);
      run_test("dint_50_32", basic_generic, 1'b1, iw50, ow32, GATE_NONE, 0, 200);
      run_test("dint_40_40", basic_generic, 1'b1, iw40, ow40, GATE_NONE, 0, 200);
      run_test("first_read_wait", basic_generic, 1'b1, iw66, ow40, GATE_NONE, 30, 100);
      run_test("phcomp_gate", phcomp, 1'b1, iw64, ow32, GATE_PHCOMP, 0, 100);
      run_test("bonded_gate", basic_generic, 1'b0, iw32, ow32, GATE_BOND, 0, 100);
      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tx_adapt.f
src/tx_adapt_pkg.sv
src/tx_fifo.sv
src/tx_dv_gen.sv
src/tx_gearbox.sv
src/tx_adapt_top.sv
dv/tx_adapt_tb.sv

// File: Makefile
# Verilator build and run for the TX adapter testbench
SIM      = verilator
TOP      = tx_adapt_tb
FILELIST = tx_adapt.f
VFLAGS   = --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Test completed successfully
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
